// ==== alu_unit.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              alu_start,
    input  cpu_pkg::alu_op_t  alu_op,
    input  cpu_pkg::word_t    op_a,
    input  cpu_pkg::word_t    op_b,
    input  cpu_pkg::rob_tag_t issue_tag,
    output logic              alu_done,
    output cpu_pkg::rob_tag_t alu_tag,
    output cpu_pkg::word_t    alu_result
);
    logic [$clog2(`XLEN)-1:0] shamt;
    cpu_pkg::word_t result;

    assign shamt = op_b[$clog2(`XLEN)-1:0];

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: result = op_a + op_b;
            cpu_pkg::ALU_SUB: result = op_a - op_b;
            cpu_pkg::ALU_AND: result = op_a & op_b;
            cpu_pkg::ALU_OR:  result = op_a | op_b;
            cpu_pkg::ALU_XOR: result = op_a ^ op_b;
            cpu_pkg::ALU_SLL: result = op_a << shamt;
            cpu_pkg::ALU_SRL: result = op_a >> shamt;
            cpu_pkg::ALU_SLT: result = cpu_pkg::word_t'($signed(op_a) < $signed(op_b));
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            alu_done <= 1'b0;
        else
            alu_done <= alu_start;
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_tag    <= issue_tag;
            alu_result <= result;
        end
    end

endmodule

// ==== arch_register_file.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module arch_register_file (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t rs1_idx,
    input  cpu_pkg::reg_idx_t rs2_idx,
    output cpu_pkg::word_t    rs1_data,
    output cpu_pkg::word_t    rs2_data,
    input  logic              commit_valid,
    input  cpu_pkg::reg_idx_t commit_rd,
    input  cpu_pkg::word_t    commit_value
);
    cpu_pkg::word_t regs [`REG_COUNT];

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (commit_valid && commit_rd != '0) begin
            regs[commit_rd] <= commit_value; // x0 stays zero
        end
    end

endmodule

// ==== cpu_checker.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_checker (
    input logic                        clk,
    input logic                        rst,
    input logic                        alu_done,
    input cpu_pkg::rob_tag_t           alu_tag,
    input logic                        mul_done,
    input cpu_pkg::rob_tag_t           mul_tag,
    input logic                        commit_valid,
    input cpu_pkg::rob_tag_t           head,
    input logic [$clog2(`ROB_DEPTH):0] count
);
    int fail_count = 0;

    // live window is head .. head+count-1, modulo depth
    function automatic logic tag_live(input cpu_pkg::rob_tag_t tag, input cpu_pkg::rob_tag_t hd,
                                      input logic [$clog2(`ROB_DEPTH):0] cnt);
        cpu_pkg::rob_tag_t off;
        off = tag - hd;
        return {1'b0, off} < cnt;
    endfunction

    commit_after_reset: assert property (@(posedge clk) rst |=> !commit_valid)
        else begin
            $error("commit_valid high in the cycle after reset");
            fail_count++;
        end

    alu_tag_allocated: assert property (@(posedge clk) disable iff (rst)
        alu_done |-> tag_live(alu_tag, head, count))
        else begin
            $error("alu completion to unallocated tag %0d", alu_tag);
            fail_count++;
        end

    mul_tag_allocated: assert property (@(posedge clk) disable iff (rst)
        mul_done |-> tag_live(mul_tag, head, count))
        else begin
            $error("mul completion to unallocated tag %0d", mul_tag);
            fail_count++;
        end

    count_in_range: assert property (@(posedge clk) disable iff (rst)
        count <= ($clog2(`ROB_DEPTH)+1)'(`ROB_DEPTH))
        else begin
            $error("rob count %0d above depth", count);
            fail_count++;
        end

    no_commit_empty: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |=> !commit_valid)
        else begin
            $error("commit from an empty rob");
            fail_count++;
        end

endmodule

bind reorder_buffer cpu_checker chk0 (
    .clk(clk), .rst(rst),
    .alu_done(alu_done), .alu_tag(alu_tag),
    .mul_done(mul_done), .mul_tag(mul_tag),
    .commit_valid(commit_valid), .head(head), .count(count)
);

// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and register file
`define XLEN        32
`define REG_COUNT   32

// reorder buffer entries, kept a power of two so the pointers wrap
`define ROB_DEPTH   8

// shift-add iterations, one per multiplier bit
`define MUL_CYCLES  32

// accepted major opcodes
`define OPC_OP      7'b0110011 // register-register, incl. mul
`define OPC_OP_IMM  7'b0010011 // addi only

`endif

// ==== cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0] word_t;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } alu_op_t;

    // iterative multiplier
    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_RUN  = 2'd1,
        MUL_DONE = 2'd2
    } mul_state_t;

endpackage

// ==== cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  cpu_pkg::word_t    inst,
    output logic              stall,
    output logic              commit_valid,
    output cpu_pkg::reg_idx_t commit_rd,
    output cpu_pkg::word_t    commit_value
);
    cpu_pkg::reg_idx_t rs1_idx;
    cpu_pkg::reg_idx_t rs2_idx;
    cpu_pkg::word_t    rs1_data;
    cpu_pkg::word_t    rs2_data;

    // issue side
    logic              issue_valid;
    cpu_pkg::reg_idx_t issue_rd;
    cpu_pkg::rob_tag_t issue_tag;
    cpu_pkg::rob_tag_t alloc_tag;
    logic              rob_full;
    logic              alu_start;
    cpu_pkg::alu_op_t  alu_op;
    logic              mul_start;
    logic              mul_busy;
    cpu_pkg::word_t    op_a;
    cpu_pkg::word_t    op_b;

    // completion side
    logic              alu_done;
    cpu_pkg::rob_tag_t alu_tag;
    cpu_pkg::word_t    alu_result;
    logic              mul_done;
    cpu_pkg::rob_tag_t mul_tag;
    cpu_pkg::word_t    mul_result;

    inst_decoder u_decoder (
        .clk(clk), .rst(rst),
        .inst_valid(inst_valid), .inst(inst),
        .rob_full(rob_full), .mul_busy(mul_busy), .alloc_tag(alloc_tag),
        .retire_valid(commit_valid), .retire_rd(commit_rd), // commit doubles as retire
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .stall(stall), .issue_valid(issue_valid), .issue_rd(issue_rd),
        .alu_start(alu_start), .alu_op(alu_op), .mul_start(mul_start),
        .op_a(op_a), .op_b(op_b), .issue_tag(issue_tag)
    );

    alu_unit u_alu (
        .clk(clk), .rst(rst),
        .alu_start(alu_start), .alu_op(alu_op), .op_a(op_a), .op_b(op_b),
        .issue_tag(issue_tag),
        .alu_done(alu_done), .alu_tag(alu_tag), .alu_result(alu_result)
    );

    multiplier u_mul (
        .clk(clk), .rst(rst),
        .mul_start(mul_start), .op_a(op_a), .op_b(op_b), .issue_tag(issue_tag),
        .mul_busy(mul_busy), .mul_done(mul_done), .mul_tag(mul_tag), .mul_result(mul_result)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_rd(issue_rd),
        .alloc_tag(alloc_tag), .rob_full(rob_full),
        .alu_done(alu_done), .alu_tag(alu_tag), .alu_result(alu_result),
        .mul_done(mul_done), .mul_tag(mul_tag), .mul_result(mul_result),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    arch_register_file u_regfile (
        .clk(clk), .rst(rst),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module inst_decoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  cpu_pkg::word_t    inst,
    input  logic              rob_full,
    input  logic              mul_busy,
    input  cpu_pkg::rob_tag_t alloc_tag,
    input  logic              retire_valid,
    input  cpu_pkg::reg_idx_t retire_rd,
    output cpu_pkg::reg_idx_t rs1_idx,
    output cpu_pkg::reg_idx_t rs2_idx,
    input  cpu_pkg::word_t    rs1_data,
    input  cpu_pkg::word_t    rs2_data,
    output logic              stall,
    output logic              issue_valid,
    output cpu_pkg::reg_idx_t issue_rd,
    output logic              alu_start,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              mul_start,
    output cpu_pkg::word_t    op_a,
    output cpu_pkg::word_t    op_b,
    output cpu_pkg::rob_tag_t issue_tag
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    cpu_pkg::word_t imm_i;
    logic is_op;
    logic is_mul;
    logic known;
    logic hazard;
    logic [`REG_COUNT-1:0] pending; // one bit per arch reg, x0 never set

    assign opcode   = inst[6:0];
    assign issue_rd = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1_idx  = inst[19:15];
    assign rs2_idx  = inst[24:20];
    assign funct7   = inst[31:25];
    assign imm_i    = {{(`XLEN-12){inst[31]}}, inst[31:20]};

    assign is_op = (opcode == `OPC_OP);

    always_comb begin
        alu_op = cpu_pkg::ALU_ADD;
        is_mul = 1'b0;
        known  = 1'b0;
        if (is_op) begin
            known = 1'b1;
            case ({funct7, funct3})
                {7'b0000000, 3'b000}: alu_op = cpu_pkg::ALU_ADD;
                {7'b0100000, 3'b000}: alu_op = cpu_pkg::ALU_SUB;
                {7'b0000000, 3'b111}: alu_op = cpu_pkg::ALU_AND;
                {7'b0000000, 3'b110}: alu_op = cpu_pkg::ALU_OR;
                {7'b0000000, 3'b100}: alu_op = cpu_pkg::ALU_XOR;
                {7'b0000000, 3'b001}: alu_op = cpu_pkg::ALU_SLL;
                {7'b0000000, 3'b101}: alu_op = cpu_pkg::ALU_SRL;
                {7'b0000000, 3'b010}: alu_op = cpu_pkg::ALU_SLT;
                {7'b0000001, 3'b000}: is_mul = 1'b1; // low word only
                default:              known  = 1'b0;
            endcase
        end else if (opcode == `OPC_OP_IMM && funct3 == 3'b000) begin
            known = 1'b1; // addi
        end
    end

    // raw on sources, waw on rd; addi has no rs2
    assign hazard = pending[rs1_idx] | (is_op & pending[rs2_idx]) | pending[issue_rd];

    // unknown words never stall, they are taken and dropped
    assign stall       = inst_valid & known & (rob_full | hazard | (is_mul & mul_busy));
    assign issue_valid = inst_valid & known & ~stall;
    assign alu_start   = issue_valid & ~is_mul;
    assign mul_start   = issue_valid & is_mul;

    assign op_a      = rs1_data;
    assign op_b      = is_op ? rs2_data : imm_i;
    assign issue_tag = alloc_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (retire_valid)
                pending[retire_rd] <= 1'b0;
            if (issue_valid && issue_rd != '0)
                pending[issue_rd] <= 1'b1; // rd is free here, so no clash with retire
        end
    end

endmodule

// ==== multiplier.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module multiplier (
    input  logic              clk,
    input  logic              rst,
    input  logic              mul_start,
    input  cpu_pkg::word_t    op_a,
    input  cpu_pkg::word_t    op_b,
    input  cpu_pkg::rob_tag_t issue_tag,
    output logic              mul_busy,
    output logic              mul_done,
    output cpu_pkg::rob_tag_t mul_tag,
    output cpu_pkg::word_t    mul_result
);
    cpu_pkg::mul_state_t state;
    cpu_pkg::word_t mcand; // shifted left each step
    cpu_pkg::word_t mplier; // shifted right, lsb picks the add
    logic [$clog2(`MUL_CYCLES)-1:0] iter;

    assign mul_busy = (state != cpu_pkg::MUL_IDLE);
    assign mul_done = (state == cpu_pkg::MUL_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cpu_pkg::MUL_IDLE;
        end else begin
            case (state)
                cpu_pkg::MUL_IDLE: if (mul_start) state <= cpu_pkg::MUL_RUN;
                cpu_pkg::MUL_RUN: begin
                    if (iter == ($clog2(`MUL_CYCLES))'(`MUL_CYCLES - 1))
                        state <= cpu_pkg::MUL_DONE;
                end
                default: state <= cpu_pkg::MUL_IDLE; // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::MUL_IDLE && mul_start) begin
            mcand      <= op_a;
            mplier     <= op_b;
            mul_tag    <= issue_tag;
            mul_result <= '0;
            iter       <= '0;
        end else if (state == cpu_pkg::MUL_RUN) begin
            if (mplier[0])
                mul_result <= mul_result + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            iter   <= iter + 1'b1;
        end
    end

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  cpu_pkg::reg_idx_t issue_rd,
    output cpu_pkg::rob_tag_t alloc_tag,
    output logic              rob_full,
    input  logic              alu_done,
    input  cpu_pkg::rob_tag_t alu_tag,
    input  cpu_pkg::word_t    alu_result,
    input  logic              mul_done,
    input  cpu_pkg::rob_tag_t mul_tag,
    input  cpu_pkg::word_t    mul_result,
    output logic              commit_valid,
    output cpu_pkg::reg_idx_t commit_rd,
    output cpu_pkg::word_t    commit_value
);
    cpu_pkg::reg_idx_t rd_q  [`ROB_DEPTH];
    cpu_pkg::word_t    val_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done_q;

    cpu_pkg::rob_tag_t head;
    cpu_pkg::rob_tag_t tail;
    logic [$clog2(`ROB_DEPTH):0] count;
    logic retire;

    assign alloc_tag = tail;
    assign rob_full  = (count == ($clog2(`ROB_DEPTH)+1)'(`ROB_DEPTH));
    assign retire    = (count != '0) && done_q[head];

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done_q       <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (alu_done)
                done_q[alu_tag] <= 1'b1;
            if (mul_done)
                done_q[mul_tag] <= 1'b1;
            if (retire) begin
                done_q[head] <= 1'b0;
                head         <= head + 1'b1; // wraps, depth is a power of two
            end
            if (issue_valid) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            case ({issue_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (issue_valid)
            rd_q[tail] <= issue_rd;
        if (alu_done)
            val_q[alu_tag] <= alu_result;
        if (mul_done)
            val_q[mul_tag] <= mul_result;
        if (retire) begin
            commit_rd    <= rd_q[head];
            commit_value <= val_q[head];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_cpu -o sim_tb_cpu

./obj_dir/sim_tb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation ok"

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu;
    localparam int CLK_PERIOD   = 100;
    localparam int N_INST       = 400;
    localparam int DRAIN_CYCLES = 40;
    localparam longint WATCHDOG_NS = longint'(N_INST) * (`MUL_CYCLES + 10) * CLK_PERIOD;

    // kinds 0..7 follow alu_op_t order
    localparam int K_ADDI = 8;
    localparam int K_MUL  = 9;
    localparam int K_BAD  = 10;

    logic              clk;
    logic              rst;
    logic              inst_valid;
    cpu_pkg::word_t    inst;
    logic              stall;
    logic              commit_valid;
    cpu_pkg::reg_idx_t commit_rd;
    cpu_pkg::word_t    commit_value;

    logic [31:0]       seed;
    cpu_pkg::word_t    model_regs [`REG_COUNT];
    cpu_pkg::reg_idx_t exp_rd_q [$];
    cpu_pkg::word_t    exp_val_q [$];

    // fields of the word currently on the bus
    int                cur_kind;
    cpu_pkg::reg_idx_t cur_rd;
    cpu_pkg::reg_idx_t cur_rs1;
    cpu_pkg::reg_idx_t cur_rs2;
    logic [11:0]       cur_imm;

    cpu_top dut0 (
        .clk(clk), .rst(rst),
        .inst_valid(inst_valid), .inst(inst),
        .stall(stall),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic random_bits(output logic [15:0] v);
        seed = next_random(seed);
        v = seed[31:16]; // low lcg bits repeat quickly
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // random op over x0..x7, small register set forces hazards
    task automatic make_instruction(output cpu_pkg::word_t word);
        logic [15:0] r;
        logic [6:0]  f7;
        logic [2:0]  f3;
        random_bits(r);
        case (r[3:0])
            4'd8, 4'd9, 4'd10, 4'd14, 4'd15: cur_kind = K_ADDI;
            4'd11, 4'd12:                    cur_kind = K_MUL;
            4'd13:                           cur_kind = K_BAD;
            default:                         cur_kind = int'(r[2:0]);
        endcase
        cur_rd  = {2'b00, r[6:4]};
        cur_rs1 = {2'b00, r[9:7]};
        cur_rs2 = {2'b00, r[12:10]};
        random_bits(r);
        cur_imm = r[11:0];
        case (cur_kind)
            0:       begin f7 = 7'b0000000; f3 = 3'b000; end // add
            1:       begin f7 = 7'b0100000; f3 = 3'b000; end // sub
            2:       begin f7 = 7'b0000000; f3 = 3'b111; end
            3:       begin f7 = 7'b0000000; f3 = 3'b110; end
            4:       begin f7 = 7'b0000000; f3 = 3'b100; end
            5:       begin f7 = 7'b0000000; f3 = 3'b001; end // sll
            6:       begin f7 = 7'b0000000; f3 = 3'b101; end // srl
            7:       begin f7 = 7'b0000000; f3 = 3'b010; end // slt
            K_MUL:   begin f7 = 7'b0000001; f3 = 3'b000; end
            default: begin f7 = 7'b0000001; f3 = 3'b100; end // div, unsupported
        endcase
        if (cur_kind == K_ADDI)
            word = {cur_imm, cur_rs1, 3'b000, cur_rd, `OPC_OP_IMM};
        else
            word = {f7, cur_rs2, cur_rs1, f3, cur_rd, `OPC_OP};
    endtask

    function automatic cpu_pkg::word_t expected_result(input int kind, input cpu_pkg::word_t a,
                                                       input cpu_pkg::word_t b);
        case (kind)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return a << b[4:0];
            6:       return a >> b[4:0];
            7:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_MUL:   return a * b; // low word of the product
            default: return a + b; // addi
        endcase
    endfunction

    task automatic record_accepted();
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t res;
        if (cur_kind != K_BAD) begin
            a = model_regs[cur_rs1];
            b = (cur_kind == K_ADDI) ? {{20{cur_imm[11]}}, cur_imm} : model_regs[cur_rs2];
            res = expected_result(cur_kind, a, b);
            if (cur_rd != '0)
                model_regs[cur_rd] = res; // x0 stays zero
            exp_rd_q.push_back(cur_rd);
            exp_val_q.push_back(res);
        end
    endtask

    // commit stream against the model, outputs stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_value("checker_fail_count", dut0.u_rob.chk0.fail_count, 32'd0);
            if (commit_valid) begin
                if (exp_rd_q.size() == 0) begin
                    check_value("commit_valid", 32'd1, 32'd0);
                end else begin
                    check_value("commit_rd", {27'b0, commit_rd}, {27'b0, exp_rd_q[0]});
                    check_value("commit_value", commit_value, exp_val_q[0]);
                    void'(exp_rd_q.pop_front());
                    void'(exp_val_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out before all instructions committed");
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        logic take;
        int accepted;
        cpu_pkg::word_t word;
        clk          = 1'b0;
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        seed         = 32'h1b28;
        accepted     = 0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // idle after reset
        repeat (4) begin
            @(negedge clk);
            check_value("stall", {31'b0, stall}, 32'd0);
            check_value("commit_valid", {31'b0, commit_valid}, 32'd0);
        end

        @(posedge clk);
        make_instruction(word);
        inst_valid <= 1'b1;
        inst       <= word;
        while (accepted < N_INST) begin
            @(negedge clk);
            take = inst_valid && !stall; // nothing changes until the next rising edge
            @(posedge clk);
            if (take) begin
                record_accepted();
                accepted++;
                if (accepted < N_INST) begin
                    make_instruction(word);
                    inst <= word;
                end else begin
                    inst_valid <= 1'b0;
                    inst       <= '0;
                end
            end
        end

        while (exp_rd_q.size() != 0)
            @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk); // stray commits would show up here

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
cpu_pkg.sv
inst_decoder.sv
alu_unit.sv
multiplier.sv
reorder_buffer.sv
arch_register_file.sv
cpu_top.sv
cpu_checker.sv
tb_cpu.sv
